//--- source/axi_agent_settings.svh
// AXI agent field widths
`ifndef AXI_AGENT_SETTINGS_SVH
`define AXI_AGENT_SETTINGS_SVH

// --------------------
// AXI side
// --------------------

// Transaction ID
`define AXI_ID_W 2

// Byte address
`define AXI_ADDR_W 32

// Data bus, four byte lanes
`define AXI_DATA_W 32

// AXI3 burst length field
`define AXI_LEN_W 4

// --------------------
// Network packet
// --------------------

// Enough for a 16 beat burst of 4 bytes
`define PKT_BYTE_CNT_W 7

`define PKT_BURSTWRAP_W 7

// Source ID of this agent on the network
`define AGENT_SRC_ID 1'b1

`endif

//--- source/axi_agent_pkg.sv
// AXI agent types
`include "axi_agent_settings.svh"
`default_nettype none

package axi_agent_pkg;

    // AXI burst encoding
    typedef enum logic [1:0]
    {
        FIXED    = 2'b00,
        INCR     = 2'b01,
        WRAP     = 2'b10,
        RESERVED = 2'b11
    } burst_type_e;

    // --------------------
    // AXI channels
    // --------------------

    // AW and AR carry the same fields
    typedef struct packed
    {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
        logic [2:0]             size;
        burst_type_e            burst;
        logic [1:0]             lock;
        logic [3:0]             cache;
        logic [2:0]             prot;
    } axi_addr_t;

    typedef struct packed
    {
        logic [`AXI_DATA_W-1:0]   data;
        logic [`AXI_DATA_W/8-1:0] strb;
        logic                     last;
    } axi_wdata_t;

    typedef struct packed
    {
        logic [`AXI_ID_W-1:0] id;
        logic [1:0]           resp;
    } axi_b_t;

    typedef struct packed
    {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        logic [1:0]             resp;
        logic                   last;
    } axi_r_t;

    // --------------------
    // Network packet
    // --------------------

    // Same layout for commands and responses
    typedef struct packed
    {
        logic [1:0]                 resp_status;
        logic [`AXI_ID_W-1:0]       thread_id;
        logic [3:0]                 cache;
        logic [2:0]                 prot;
        burst_type_e                burst_type;
        logic [2:0]                 burst_size;
        logic [`PKT_BURSTWRAP_W-1:0] burstwrap;
        logic [`PKT_BYTE_CNT_W-1:0] byte_cnt;
        logic                       exclusive;
        logic                       compressed_read;
        logic                       write;
        logic                       read;
        logic [`AXI_ADDR_W-1:0]     addr;
        logic [`AXI_DATA_W-1:0]     data;
        logic [`AXI_DATA_W/8-1:0]   byteen;
        logic                       src_id;
    } net_pkt_t;

    // Bytes per beat for an AxSIZE value
    function automatic logic [7:0] size_bytes(input logic [2:0] size);
        return 8'd1 << size;
    endfunction

endpackage

`default_nettype wire

//--- source/burst_decode.sv
// Burst wrap and bytecount decode
`timescale 1ns/1ns
`include "axi_agent_settings.svh"
`default_nettype none

module burst_decode
(
    input  axi_agent_pkg::axi_addr_t     cmd,
    output logic [`PKT_BURSTWRAP_W-1:0] burstwrap,
    output logic [`PKT_BYTE_CNT_W-1:0]  total_byte_cnt
);

    import axi_agent_pkg::*;

    localparam int BEAT_SHIFT = $clog2(`AXI_DATA_W / 8);
    localparam int LOG_W      = $clog2(`AXI_LEN_W + 1);

    logic [LOG_W-1:0]                len_log2;
    logic [4:0]                      wrap_width;
    logic [`PKT_BURSTWRAP_W-2:0]     wrap_mask;
    logic [7:0]                      fixed_mask;
    logic [`AXI_LEN_W+BEAT_SHIFT:0] total_wide;

    // ceil(log2(len + 1)) is the bit length of len
    always_comb
    begin
        len_log2 = '0;
        for (int i = 0; i < `AXI_LEN_W; i++)
        begin
            if (cmd.len[i])
                len_log2 = LOG_W'(i + 1);
        end
    end

    // Wrap boundary as a low bit mask
    assign wrap_width = 5'(cmd.size) + 5'(len_log2);

    always_comb
    begin
        for (int i = 0; i < `PKT_BURSTWRAP_W - 1; i++)
            wrap_mask[i] = (wrap_width > i);
    end

    // FIXED stays inside one beat
    assign fixed_mask = size_bytes(cmd.size) - 8'd1;

    always_comb
    begin
        case (cmd.burst)
            INCR:    burstwrap = '1;
            WRAP:    burstwrap = {1'b0, wrap_mask};
            FIXED:   burstwrap = fixed_mask[`PKT_BURSTWRAP_W-1:0];
            default: burstwrap = '1;
        endcase
    end

    // Full bus width on every beat
    assign total_wide     = ({1'b0, cmd.len} + 1'b1) << BEAT_SHIFT;
    assign total_byte_cnt = total_wide[`PKT_BYTE_CNT_W-1:0];

endmodule

`default_nettype wire

//--- source/write_beat_address.sv
// Write beat address generator
`timescale 1ns/1ns
`include "axi_agent_settings.svh"
`default_nettype none

module write_beat_address
(
    input  wire                          aclk,
    input  wire                          aresetn,
    input  axi_agent_pkg::axi_addr_t     aw,
    input  wire [`PKT_BURSTWRAP_W-1:0]   burstwrap,
    input  wire                          first_beat,
    input  wire                          beat_accept,
    output logic [`AXI_ADDR_W-1:0]       beat_addr
);

    import axi_agent_pkg::*;

    logic [`AXI_ADDR_W-1:0] start_addr;
    logic [`AXI_ADDR_W-1:0] cur_addr;
    logic [`AXI_ADDR_W-1:0] incr_addr;
    logic [`AXI_ADDR_W-1:0] next_addr;
    logic [`AXI_ADDR_W-1:0] wrap_mask;
    logic [`AXI_ADDR_W-1:0] addr_q;

    // --------------------
    // Current beat
    // --------------------

    // Start address aligned to the transfer size
    assign start_addr = aw.addr & ({`AXI_ADDR_W{1'b1}} << aw.size);

    // Register is stale on the first beat of a burst
    assign cur_addr  = first_beat ? start_addr : addr_q;
    assign beat_addr = cur_addr;

    // --------------------
    // Next beat
    // --------------------

    assign incr_addr = cur_addr + {{(`AXI_ADDR_W-8){1'b0}}, size_bytes(aw.size)};
    assign wrap_mask = {{(`AXI_ADDR_W-`PKT_BURSTWRAP_W){1'b0}}, burstwrap};

    always_comb
    begin
        case (aw.burst)
            FIXED:
                next_addr = cur_addr;
            WRAP:
                // Upper bits pinned to the wrap window
                next_addr = (start_addr & ~wrap_mask) | (incr_addr & wrap_mask);
            default:
                next_addr = incr_addr;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            addr_q <= '0;
        end
        else if (beat_accept)
        begin
            addr_q <= next_addr;
        end
    end

endmodule

`default_nettype wire

//--- source/write_cmd_channel.sv
// Write command packet channel
`timescale 1ns/1ns
`include "axi_agent_settings.svh"
`default_nettype none

module write_cmd_channel
(
    input  wire                        aclk,
    input  wire                        aresetn,
    input  axi_agent_pkg::axi_addr_t   aw,
    input  wire                        awvalid,
    output logic                       awready,
    input  axi_agent_pkg::axi_wdata_t  w,
    input  wire                        wvalid,
    output logic                       wready,
    output logic                       write_cp_valid,
    output axi_agent_pkg::net_pkt_t    write_cp_data,
    output logic                       write_cp_startofpacket,
    output logic                       write_cp_endofpacket,
    input  wire                        write_cp_ready
);

    localparam logic [`PKT_BYTE_CNT_W-1:0] BEAT_BYTES = `AXI_DATA_W / 8;

    logic                         both_valid;
    logic                         beat_accept;
    logic                         sop_q;
    logic [`PKT_BURSTWRAP_W-1:0] burstwrap;
    logic [`PKT_BYTE_CNT_W-1:0]  total_byte_cnt;
    logic [`PKT_BYTE_CNT_W-1:0]  byte_cnt_q;
    logic [`PKT_BYTE_CNT_W-1:0]  beat_byte_cnt;
    logic [`AXI_ADDR_W-1:0]      beat_addr;

    // --------------------
    // Handshake
    // --------------------

    // A beat goes out only with both address and data present
    assign both_valid     = awvalid && wvalid;
    assign beat_accept    = both_valid && write_cp_ready;
    assign write_cp_valid = both_valid;
    assign wready         = beat_accept;

    // AW held until the last data beat is taken
    assign awready = beat_accept && w.last;

    assign write_cp_startofpacket = sop_q;
    assign write_cp_endofpacket   = w.last;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            sop_q      <= 1'b1;
            byte_cnt_q <= '0;
        end
        else if (beat_accept)
        begin
            sop_q      <= w.last;
            byte_cnt_q <= beat_byte_cnt - BEAT_BYTES;
        end
    end

    // Remaining bytes including this beat
    assign beat_byte_cnt = sop_q ? total_byte_cnt : byte_cnt_q;

    burst_decode i_burst_decode
    (
        .cmd            (aw),
        .burstwrap      (burstwrap),
        .total_byte_cnt (total_byte_cnt)
    );

    write_beat_address i_write_beat_address
    (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .aw          (aw),
        .burstwrap   (burstwrap),
        .first_beat  (sop_q),
        .beat_accept (beat_accept),
        .beat_addr   (beat_addr)
    );

    // --------------------
    // Packet
    // --------------------

    always_comb
    begin
        write_cp_data                 = '0;
        write_cp_data.thread_id       = aw.id;
        write_cp_data.cache           = aw.cache;
        write_cp_data.prot            = aw.prot;
        write_cp_data.burst_type      = aw.burst;
        write_cp_data.burst_size      = aw.size;
        write_cp_data.burstwrap       = burstwrap;
        write_cp_data.byte_cnt        = beat_byte_cnt;
        write_cp_data.exclusive       = aw.lock[0];
        write_cp_data.compressed_read = 1'b0;
        write_cp_data.write           = 1'b1;
        write_cp_data.read            = 1'b0;
        write_cp_data.addr            = beat_addr;
        write_cp_data.data            = w.data;
        write_cp_data.byteen          = w.strb;
        write_cp_data.src_id          = `AGENT_SRC_ID;
    end

endmodule

`default_nettype wire

//--- source/read_cmd_channel.sv
// Read command packet channel
`timescale 1ns/1ns
`include "axi_agent_settings.svh"
`default_nettype none

module read_cmd_channel
(
    input  axi_agent_pkg::axi_addr_t ar,
    input  wire                      arvalid,
    output logic                     arready,
    output logic                     read_cp_valid,
    output axi_agent_pkg::net_pkt_t  read_cp_data,
    input  wire                      read_cp_ready
);

    logic [`PKT_BURSTWRAP_W-1:0] burstwrap;
    logic [`PKT_BYTE_CNT_W-1:0]  total_byte_cnt;

    // One packet per AR, so the handshake passes straight through
    assign read_cp_valid = arvalid;
    assign arready       = read_cp_ready;

    burst_decode i_burst_decode
    (
        .cmd            (ar),
        .burstwrap      (burstwrap),
        .total_byte_cnt (total_byte_cnt)
    );

    // Whole burst in one compressed read, address left as issued
    always_comb
    begin
        read_cp_data                 = '0;
        read_cp_data.thread_id       = ar.id;
        read_cp_data.cache           = ar.cache;
        read_cp_data.prot            = ar.prot;
        read_cp_data.burst_type      = ar.burst;
        read_cp_data.burst_size      = ar.size;
        read_cp_data.burstwrap       = burstwrap;
        read_cp_data.byte_cnt        = total_byte_cnt;
        read_cp_data.exclusive       = ar.lock[0];
        read_cp_data.compressed_read = 1'b1;
        read_cp_data.write           = 1'b0;
        read_cp_data.read            = 1'b1;
        read_cp_data.addr            = ar.addr;
        read_cp_data.data            = '0;
        read_cp_data.byteen          = '1;
        read_cp_data.src_id          = `AGENT_SRC_ID;
    end

endmodule

`default_nettype wire

//--- source/axi_master_agent.sv
// AXI3 master network agent
`timescale 1ns/1ns
`default_nettype none

module axi_master_agent
(
    input  wire                        aclk,
    input  wire                        aresetn,

    // --------------------
    // AXI side
    // --------------------
    input  axi_agent_pkg::axi_addr_t   aw,
    input  wire                        awvalid,
    output logic                       awready,

    input  axi_agent_pkg::axi_wdata_t  w,
    input  wire                        wvalid,
    output logic                       wready,

    output axi_agent_pkg::axi_b_t      b,
    output logic                       bvalid,
    input  wire                        bready,

    input  axi_agent_pkg::axi_addr_t   ar,
    input  wire                        arvalid,
    output logic                       arready,

    output axi_agent_pkg::axi_r_t      r,
    output logic                       rvalid,
    input  wire                        rready,

    // --------------------
    // Network side
    // --------------------
    output logic                       write_cp_valid,
    output axi_agent_pkg::net_pkt_t    write_cp_data,
    output logic                       write_cp_startofpacket,
    output logic                       write_cp_endofpacket,
    input  wire                        write_cp_ready,

    input  wire                        write_rp_valid,
    input  axi_agent_pkg::net_pkt_t    write_rp_data,
    input  wire                        write_rp_endofpacket,
    output logic                       write_rp_ready,

    output logic                       read_cp_valid,
    output axi_agent_pkg::net_pkt_t    read_cp_data,
    output logic                       read_cp_startofpacket,
    output logic                       read_cp_endofpacket,
    input  wire                        read_cp_ready,

    input  wire                        read_rp_valid,
    input  axi_agent_pkg::net_pkt_t    read_rp_data,
    input  wire                        read_rp_endofpacket,
    output logic                       read_rp_ready
);

    write_cmd_channel i_write_cmd_channel
    (
        .aclk                   (aclk),
        .aresetn                (aresetn),
        .aw                     (aw),
        .awvalid                (awvalid),
        .awready                (awready),
        .w                      (w),
        .wvalid                 (wvalid),
        .wready                 (wready),
        .write_cp_valid         (write_cp_valid),
        .write_cp_data          (write_cp_data),
        .write_cp_startofpacket (write_cp_startofpacket),
        .write_cp_endofpacket   (write_cp_endofpacket),
        .write_cp_ready         (write_cp_ready)
    );

    read_cmd_channel i_read_cmd_channel
    (
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .read_cp_valid (read_cp_valid),
        .read_cp_data  (read_cp_data),
        .read_cp_ready (read_cp_ready)
    );

    // Read commands are always single beat packets
    assign read_cp_startofpacket = 1'b1;
    assign read_cp_endofpacket   = 1'b1;

    // --------------------
    // Responses
    // --------------------

    // One B per response packet, raised on its final beat
    assign bvalid         = write_rp_valid && write_rp_endofpacket;
    assign write_rp_ready = bready;
    assign b.id           = write_rp_data.thread_id;
    assign b.resp         = write_rp_data.resp_status;

    // Every read response beat becomes an R beat
    assign rvalid        = read_rp_valid;
    assign read_rp_ready = rready;
    assign r.id          = read_rp_data.thread_id;
    assign r.data        = read_rp_data.data;
    assign r.resp        = read_rp_data.resp_status;
    assign r.last        = read_rp_endofpacket;

endmodule

`default_nettype wire

//--- tb/tb_axi_master_agent.sv
// AXI master agent testbench
`timescale 1ns/1ns
`include "axi_agent_settings.svh"
`default_nettype none

module tb_axi_master_agent;

    import axi_agent_pkg::*;

    localparam int N_BURSTS = 20;
    localparam int N_WRITES = 3 * N_BURSTS;
    localparam int N_READS  = 20;
    localparam int N_RESPS  = 20;
    // Ten times the worst case of 16 beats at about 2 cycles each
    localparam int TIMEOUT_CYCLES = 10 * (N_WRITES * 16 * 2 + (N_READS + N_RESPS) * 2);

    logic       aclk = 1'b0;
    logic       aresetn;
    axi_addr_t  aw;
    logic       awvalid;
    logic       awready;
    axi_wdata_t w;
    logic       wvalid;
    logic       wready;
    axi_b_t     b;
    logic       bvalid;
    logic       bready;
    axi_addr_t  ar;
    logic       arvalid;
    logic       arready;
    axi_r_t     r;
    logic       rvalid;
    logic       rready;
    logic       write_cp_valid;
    net_pkt_t   write_cp_data;
    logic       write_cp_startofpacket;
    logic       write_cp_endofpacket;
    logic       write_cp_ready;
    logic       write_rp_valid;
    net_pkt_t   write_rp_data;
    logic       write_rp_endofpacket;
    logic       write_rp_ready;
    logic       read_cp_valid;
    net_pkt_t   read_cp_data;
    logic       read_cp_startofpacket;
    logic       read_cp_endofpacket;
    logic       read_cp_ready;
    logic       read_rp_valid;
    net_pkt_t   read_rp_data;
    logic       read_rp_endofpacket;
    logic       read_rp_ready;

    logic [31:0] stim_lfsr  = 32'h3506;
    logic [31:0] ready_lfsr = 32'h3506;
    logic        bp_on      = 1'b0;
    string       test_name  = "reset";
    int          wbeat       = 0;
    int          bursts_done = 0;
    int          aw_pulses   = 0;
    int          reads_done  = 0;
    int          b_done      = 0;
    int          r_done      = 0;
    int          cycle_cnt   = 0;

    axi_master_agent i_dut (.*);

    always #20 aclk = ~aclk;

    // --------------------
    // Random numbers
    // --------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
    endtask

    // --------------------
    // Reference model
    // --------------------

    function automatic logic [`PKT_BURSTWRAP_W-1:0] wrap_mask_of(input axi_addr_t cmd);
        int beats_log2;
        logic [`PKT_BURSTWRAP_W-1:0] mask;
        beats_log2 = 0;
        while ((1 << beats_log2) < cmd.len + 1)
            beats_log2++;
        mask = '1;
        if (cmd.burst == WRAP)
        begin
            // Window of beats times size, top bit clear
            mask = '0;
            for (int i = 0; i < `PKT_BURSTWRAP_W - 1; i++)
                mask[i] = (i < cmd.size + beats_log2);
        end
        else if (cmd.burst == FIXED)
        begin
            mask = (1 << cmd.size) - 1;
        end
        return mask;
    endfunction

    // AXI address of a beat, wrap window aligned to its own size
    function automatic logic [`AXI_ADDR_W-1:0] beat_address(input axi_addr_t cmd, input int beat);
        int unsigned bytes;
        int unsigned window;
        logic [`AXI_ADDR_W-1:0] start;
        logic [`AXI_ADDR_W-1:0] base;
        bytes  = 1 << cmd.size;
        window = bytes * (cmd.len + 1);
        start  = cmd.addr & ~(bytes - 1);
        base   = cmd.addr & ~(window - 1);
        case (cmd.burst)
            FIXED:   return start;
            WRAP:    return base + ((start - base + beat * bytes) % window);
            default: return start + beat * bytes;
        endcase
    endfunction

    function automatic net_pkt_t base_fields(input axi_addr_t cmd);
        net_pkt_t pkt;
        pkt            = '0;
        pkt.thread_id  = cmd.id;
        pkt.cache      = cmd.cache;
        pkt.prot       = cmd.prot;
        pkt.burst_type = cmd.burst;
        pkt.burst_size = cmd.size;
        pkt.burstwrap  = wrap_mask_of(cmd);
        pkt.exclusive  = cmd.lock[0];
        pkt.src_id     = `AGENT_SRC_ID;
        return pkt;
    endfunction

    function automatic net_pkt_t write_pkt_model(input axi_addr_t cmd, input axi_wdata_t wd,
                                                 input int beat);
        net_pkt_t pkt;
        pkt          = base_fields(cmd);
        // Bytes still to go, this beat included
        pkt.byte_cnt = (cmd.len + 1 - beat) * (`AXI_DATA_W / 8);
        pkt.write    = 1'b1;
        pkt.addr     = beat_address(cmd, beat);
        pkt.data     = wd.data;
        pkt.byteen   = wd.strb;
        return pkt;
    endfunction

    function automatic net_pkt_t read_pkt_model(input axi_addr_t cmd);
        net_pkt_t pkt;
        pkt                 = base_fields(cmd);
        pkt.byte_cnt        = (cmd.len + 1) * (`AXI_DATA_W / 8);
        pkt.read            = 1'b1;
        pkt.compressed_read = 1'b1;
        pkt.addr            = cmd.addr;
        pkt.byteen          = '1;
        return pkt;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("[ERROR] %s %s expected %b actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_pkt(input string what, input net_pkt_t exp, input net_pkt_t act);
        if (exp !== act)
        begin
            $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_b(input string what, input axi_b_t exp, input axi_b_t act);
        if (exp !== act)
        begin
            $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_r(input string what, input axi_r_t exp, input axi_r_t act);
        if (exp !== act)
        begin
            $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act)
        begin
            $display("[ERROR] %s %s expected %0d actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------

    task automatic make_cmd(input burst_type_e bt, output axi_addr_t cmd);
        logic [31:0] rnd;
        get_bits(32, rnd);
        cmd.addr = rnd;
        get_bits(13, rnd);
        cmd.id    = rnd[1:0];
        cmd.lock  = rnd[3:2];
        cmd.cache = rnd[7:4];
        cmd.prot  = rnd[10:8];
        cmd.size  = (rnd[12:11] == 2'd3) ? 3'd2 : {1'b0, rnd[12:11]};
        get_bits(4, rnd);
        cmd.len   = rnd[3:0];
        // WRAP bursts take 2, 4, 8 or 16 beats
        if (bt == WRAP)
            cmd.len = 4'((5'd2 << rnd[1:0]) - 5'd1);
        cmd.burst = bt;
    endtask

    task automatic send_write_burst(input axi_addr_t cmd);
        logic [31:0] rnd;
        axi_wdata_t wd;
        for (int i = 0; i <= cmd.len; i++)
        begin
            get_bits(32, rnd);
            wd.data = rnd;
            get_bits(4, rnd);
            wd.strb = rnd[3:0];
            wd.last = (i == cmd.len);
            @(posedge aclk);
            aw      <= cmd;
            awvalid <= 1'b1;
            w       <= wd;
            wvalid  <= 1'b1;
            do
                @(negedge aclk);
            while (!wready);
        end
        @(posedge aclk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic issue_read(input axi_addr_t cmd);
        @(posedge aclk);
        ar      <= cmd;
        arvalid <= 1'b1;
        do
            @(negedge aclk);
        while (!arready);
        @(posedge aclk);
        arvalid <= 1'b0;
    endtask

    // Write response of one or two beats, then one R beat with a random last flag
    task automatic return_responses();
        logic [31:0] rnd;
        net_pkt_t pkt;
        pkt = '0;
        get_bits(32, rnd);
        pkt.data = rnd;
        get_bits(6, rnd);
        pkt.thread_id   = rnd[1:0];
        pkt.resp_status = rnd[3:2];
        @(posedge aclk);
        write_rp_valid       <= 1'b1;
        write_rp_data        <= pkt;
        write_rp_endofpacket <= rnd[5];
        do
            @(negedge aclk);
        while (!write_rp_ready);
        if (!rnd[5])
        begin
            // Final beat of a two beat response
            @(posedge aclk);
            write_rp_endofpacket <= 1'b1;
            do
                @(negedge aclk);
            while (!write_rp_ready);
        end
        @(posedge aclk);
        write_rp_valid      <= 1'b0;
        read_rp_valid       <= 1'b1;
        read_rp_data        <= pkt;
        read_rp_endofpacket <= rnd[4];
        do
            @(negedge aclk);
        while (!read_rp_ready);
        @(posedge aclk);
        read_rp_valid <= 1'b0;
    endtask

    // Network and AXI readies, random only under back-pressure
    always @(posedge aclk)
    begin : drive_ready
        logic [3:0] rdy;
        for (int k = 0; k < 4; k++)
        begin
            ready_lfsr = lfsr_step(ready_lfsr);
            rdy[k] = ready_lfsr[0];
        end
        write_cp_ready <= bp_on ? rdy[0] : 1'b1;
        read_cp_ready  <= bp_on ? rdy[1] : 1'b1;
        bready         <= bp_on ? rdy[2] : 1'b1;
        rready         <= bp_on ? rdy[3] : 1'b1;
    end

    always @(posedge aclk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles with the tests still running", cycle_cnt);
            abort_run();
        end
    end

    // --------------------
    // Checking
    // --------------------

    always @(negedge aclk)
    begin : compare_beats
        axi_b_t exp_b;
        axi_r_t exp_r;
        if (aresetn)
        begin
            check_bit("write_cp_valid", awvalid && wvalid, write_cp_valid);
            check_bit("wready", awvalid && wvalid && write_cp_ready, wready);
            check_bit("awready", awvalid && wvalid && write_cp_ready && wbeat == aw.len,
                      awready);
            if (awvalid && wvalid && write_cp_ready)
            begin
                check_pkt("write packet", write_pkt_model(aw, w, wbeat), write_cp_data);
                check_bit("startofpacket", wbeat == 0, write_cp_startofpacket);
                check_bit("endofpacket", wbeat == aw.len, write_cp_endofpacket);
                if (wbeat == aw.len)
                begin
                    wbeat = 0;
                    bursts_done++;
                end
                else
                begin
                    wbeat++;
                end
            end
            if (awready)
                aw_pulses++;

            check_bit("read_cp_valid", arvalid, read_cp_valid);
            check_bit("arready", read_cp_ready, arready);
            if (arvalid && read_cp_ready)
            begin
                check_pkt("read packet", read_pkt_model(ar), read_cp_data);
                check_bit("read startofpacket", 1'b1, read_cp_startofpacket);
                check_bit("read endofpacket", 1'b1, read_cp_endofpacket);
                reads_done++;
            end

            // One B per write response packet, on its final beat
            check_bit("bvalid", write_rp_valid && write_rp_endofpacket, bvalid);
            check_bit("write_rp_ready", bready, write_rp_ready);
            check_bit("rvalid", read_rp_valid, rvalid);
            check_bit("read_rp_ready", rready, read_rp_ready);
            exp_b.id   = write_rp_data.thread_id;
            exp_b.resp = write_rp_data.resp_status;
            exp_r.id   = read_rp_data.thread_id;
            exp_r.data = read_rp_data.data;
            exp_r.resp = read_rp_data.resp_status;
            exp_r.last = read_rp_endofpacket;
            if (write_rp_valid)
                check_b("B beat", exp_b, b);
            if (read_rp_valid)
                check_r("R beat", exp_r, r);
            if (bvalid && bready)
                b_done++;
            if (rvalid && rready)
                r_done++;
        end
    end

    // --------------------
    // Test sequence
    // --------------------

    initial
    begin
        axi_addr_t cmd;
        logic [31:0] rnd;
        aresetn              = 1'b0;
        aw                   = '0;
        awvalid              = 1'b0;
        w                    = '0;
        wvalid               = 1'b0;
        bready               = 1'b0;
        ar                   = '0;
        arvalid              = 1'b0;
        rready               = 1'b0;
        write_cp_ready       = 1'b0;
        write_rp_valid       = 1'b0;
        write_rp_data        = '0;
        write_rp_endofpacket = 1'b1;
        read_cp_ready        = 1'b0;
        read_rp_valid        = 1'b0;
        read_rp_data         = '0;
        read_rp_endofpacket  = 1'b0;
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;

        test_name = "incr_writes";
        for (int i = 0; i < N_BURSTS; i++)
        begin
            make_cmd(INCR, cmd);
            send_write_burst(cmd);
        end

        test_name = "wrap_fixed_writes";
        for (int i = 0; i < N_BURSTS; i++)
        begin
            make_cmd((i % 2) ? WRAP : FIXED, cmd);
            send_write_burst(cmd);
        end

        test_name = "backpressure_writes";
        bp_on <= 1'b1;
        for (int i = 0; i < N_BURSTS; i++)
        begin
            get_bits(2, rnd);
            make_cmd(burst_type_e'(rnd[1:0]), cmd);
            send_write_burst(cmd);
        end

        test_name = "reads";
        for (int i = 0; i < N_READS; i++)
        begin
            get_bits(2, rnd);
            make_cmd(burst_type_e'(rnd[1:0]), cmd);
            issue_read(cmd);
        end

        test_name = "responses";
        for (int i = 0; i < N_RESPS; i++)
            return_responses();

        repeat (2) @(posedge aclk);
        test_name = "summary";
        check_count("write bursts", N_WRITES, bursts_done);
        check_count("awready pulses", N_WRITES, aw_pulses);
        check_count("read commands", N_READS, reads_done);
        check_count("B beats", N_RESPS, b_done);
        check_count("R beats", N_RESPS, r_done);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/axi_agent_pkg.sv
source/burst_decode.sv
source/write_beat_address.sv
source/write_cmd_channel.sv
source/read_cmd_channel.sv
source/axi_master_agent.sv
tb/tb_axi_master_agent.sv
